// File: project.f
src/stage_pkg.sv
src/operand_bank.sv
src/lane_format_a.sv
src/lane_format_b.sv
src/operand_chain.sv
src/operand_stage_top.sv
verif/operand_stage_assertions.sv
verif/tb_operand_stage.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= tb_operand_stage
FILELIST  ?= project.f
PASS_MSG  := Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: verif/tb_operand_stage.sv
//////////////////////////////////////////////////////////////
// testbench for the operand staging stage, random bank
// contents and reads checked against a lane model
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_operand_stage;
    import stage_pkg::*;

    logic                          clk;
    logic                          rst;
    logic                          en_a, cmen_a, en_b, cmen_b;
    logic [ADDR_W-1:0]             rdaddr_a, rdaddr_b;
    logic [1:0]                    dtype, shape;
    logic                          wr_en, wr_side;
    logic [2:0]                    wr_lane;
    logic [ADDR_W-1:0]             wr_addr;
    sram_word_t                    wr_data;
    logic [LANES-1:0][DATA_W-1:0]  a_data, b_data;
    logic [LANES-1:0]              a_en, a_cmen, b_en, b_cmen;

    sram_word_t  bank_a [LANES][BANK_DEPTH];  // model copies of the banks
    sram_word_t  bank_b [LANES][BANK_DEPTH];
    logic [32:0] exp_a [LANES][$];            // {cmen, data}
    logic [32:0] exp_b [LANES][$];
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    logic        rst_seen = 1'b0;

    operand_stage_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] expect_a(sram_word_t w, logic [1:0] dt,
                                             logic [1:0] sh, logic s);
        logic [31:0] r;
        r = w.word;
        if (dt == DT_FP16) begin
            r = {16'h0000, w.word[s*16 +: 16]};
        end else if (dt == DT_INT8 && sh == SH_SQUARE) begin
            r = {w.word[(2*s+1)*8 +: 8], w.word[(2*s+1)*8 +: 8],
                 w.word[2*s*8 +: 8], w.word[2*s*8 +: 8]};
        end else if (dt == DT_INT8 && sh == SH_NARROW) begin
            r = {4{w.word[s*8 +: 8]}};
        end else if (dt == DT_INT4 && sh == SH_WIDE) begin
            r = {w.bytes[3][7:4], w.bytes[2][7:4], w.bytes[1][7:4], w.bytes[0][7:4],
                 w.bytes[3][3:0], w.bytes[2][3:0], w.bytes[1][3:0], w.bytes[0][3:0]};
        end else if (dt == DT_INT4 && sh == SH_SQUARE) begin
            r = {2{w.bytes[1][7:4], w.bytes[0][7:4], w.bytes[1][3:0], w.bytes[0][3:0]}};
        end else if (dt == DT_INT4 && sh == SH_NARROW) begin
            r = {{4{w.word[7:4]}}, {4{w.word[3:0]}}};
        end
        return r;
    endfunction

    function automatic logic [31:0] expect_b(sram_word_t w, logic [1:0] dt,
                                             logic [1:0] sh, logic s);
        logic [31:0] r;
        r = w.word;
        if (dt == DT_FP16 && (sh == SH_SQUARE || sh == SH_NARROW)) begin
            r = {16'h0000, w.word[s*16 +: 16]};
        end else if (dt == DT_INT8 && sh == SH_WIDE) begin
            r = {4{w.word[s*8 +: 8]}};
        end else if (dt == DT_INT4 && sh == SH_WIDE) begin
            r = {{4{w.word[7:4]}}, {4{w.word[3:0]}}};
        end else if (dt == DT_INT4 && sh == SH_SQUARE) begin
            r = {2{w.word[15:0]}};
        end
        return r;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < LANES; i++) n += exp_a[i].size() + exp_b[i].size();
        return n;
    endfunction

    // outputs sampled at the edge, before the stage updates
    always @(posedge clk) begin
        logic [32:0] e;
        if (rst) begin
            if (rst_seen) begin
                assert (a_en == '0 && a_cmen == '0 && b_en == '0 && b_cmen == '0) else begin
                    $display("enable or cmen high during reset at %0t", $time);
                    errors++;
                end
            end
            rst_seen = 1'b1;  // first edge still shows the power-up state
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (a_en[i]) begin
                    assert (exp_a[i].size() > 0) else begin
                        $display("unexpected a_en on lane %0d at %0t", i, $time);
                        errors++;
                    end
                    if (exp_a[i].size() > 0) begin
                        e = exp_a[i].pop_front();
                        assert (a_data[i] == e[31:0]) else begin
                            $display("Mismatch at %0t: a_data[%0d] got %h expected %h",
                                     $time, i, a_data[i], e[31:0]);
                            errors++;
                        end
                        assert (a_cmen[i] == e[32]) else begin
                            $display("Mismatch at %0t: a_cmen[%0d] got %b expected %b",
                                     $time, i, a_cmen[i], e[32]);
                            errors++;
                        end
                    end
                end
                if (b_en[i]) begin
                    assert (exp_b[i].size() > 0) else begin
                        $display("unexpected b_en on lane %0d at %0t", i, $time);
                        errors++;
                    end
                    if (exp_b[i].size() > 0) begin
                        e = exp_b[i].pop_front();
                        assert (b_data[i] == e[31:0]) else begin
                            $display("Mismatch at %0t: b_data[%0d] got %h expected %h",
                                     $time, i, b_data[i], e[31:0]);
                            errors++;
                        end
                        assert (b_cmen[i] == e[32]) else begin
                            $display("Mismatch at %0t: b_cmen[%0d] got %b expected %b",
                                     $time, i, b_cmen[i], e[32]);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    task automatic write_word(input logic side, input int lane, input logic [9:0] addr,
                              input logic [31:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_side <= side;
        wr_lane <= lane[2:0];
        wr_addr <= addr;
        wr_data <= data;
        if (side) bank_b[lane][addr[9:2]].word = data;
        else bank_a[lane][addr[9:2]].word = data;
    endtask

    task automatic set_mode(input logic [1:0] dt, input logic [1:0] sh);
        @(posedge clk);
        wr_en <= 1'b0;
        dtype <= dt;
        shape <= sh;
    endtask

    task automatic issue(input logic va, input logic [9:0] aa, input logic vb,
                         input logic [9:0] ab);
        logic ca;
        logic cb;
        ca = 1'($urandom);
        cb = 1'($urandom);
        @(posedge clk);
        en_a <= va;
        cmen_a <= ca;
        rdaddr_a <= aa;
        en_b <= vb;
        cmen_b <= cb;
        rdaddr_b <= ab;
        for (int i = 0; i < LANES; i++) begin
            if (va) exp_a[i].push_back({ca, expect_a(bank_a[i][aa[9:2]], dtype, shape, aa[1])});
            if (vb) exp_b[i].push_back({cb, expect_b(bank_b[i][ab[9:2]], dtype, shape, ab[1])});
        end
    endtask

    task automatic drain();
        int n;
        issue(1'b0, '0, 1'b0, '0);
        for (n = 0; n < 200 && pending() > 0; n++) @(posedge clk);
        if (pending() > 0) begin
            $display("timeout, %0d expected words never arrived", pending());
            errors++;
        end
    endtask

    task automatic report(input string name, input int start);
        tests++;
        if (errors != start) failed++;
        $display("%s: %s (%0d errors)", name, errors == start ? "ok" : "FAIL",
                 errors - start);
    endtask

    task automatic check_skew(input logic side);
        logic [LANES-1:0] want;
        logic [LANES-1:0] got;
        issue(!side, 10'h04, side, 10'h04);
        for (int k = 1; k <= 11; k++) begin
            @(posedge clk);
            if (k == 1) begin
                en_a <= 1'b0;
                en_b <= 1'b0;
            end
            want = (k >= 2 && k <= 9) ? LANES'(1) << (k - 2) : '0;
            got = side ? b_en : a_en;
            assert (got == want) else begin
                $display("Mismatch at %0t: %s_en got %b expected %b",
                         $time, side ? "b" : "a", got, want);
                errors++;
            end
        end
    endtask

    initial begin
        int start;
        logic [9:0] wa [20];
        void'($urandom(80039));
        rst = 1'b1;
        {en_a, cmen_a, en_b, cmen_b, wr_en, wr_side} = '0;
        {rdaddr_a, rdaddr_b, wr_addr, wr_lane} = '0;
        dtype = DT_FP16;
        shape = SH_SQUARE;
        wr_data = '0;

        start = errors;  // reset
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (6) @(posedge clk);
        report("reset", start);

        for (int sd = 0; sd < 2; sd++)
            for (int l = 0; l < LANES; l++)
                for (int w = 0; w < BANK_DEPTH; w++)
                    write_word(sd[0], l, 10'(w * 4), $urandom);
        set_mode(DT_FP16, SH_SQUARE);

        start = errors;
        check_skew(1'b0);
        check_skew(1'b1);
        drain();
        report("skew", start);

        for (int sd = 0; sd < 2; sd++) begin
            start = errors;
            for (int dt = 0; dt < 3; dt++) begin
                for (int sh = 0; sh < 3; sh++) begin
                    set_mode(dt[1:0], sh[1:0]);
                    repeat (20) issue(sd == 0 || 1'($urandom), 10'($urandom),
                                      sd == 1, 10'($urandom));
                    drain();
                end
            end
            report(sd == 0 ? "side a formatting" : "side b formatting", start);
        end

        start = errors;  // half select and raw words
        for (int dt = 0; dt < 4; dt += 3) begin
            set_mode(dt[1:0], SH_SQUARE);
            for (int k = 0; k < 16; k++) begin
                issue(1'b1, {8'($urandom), k[0], 1'b0}, 1'b1, {8'($urandom), ~k[0], 1'b0});
            end
            drain();
        end
        report("half select and raw", start);

        start = errors;  // write then read back
        for (int k = 0; k < 20; k++) begin
            wa[k] = 10'($urandom);
            write_word(k[0], k % LANES, wa[k], $urandom);
        end
        set_mode(2'd3, SH_SQUARE);  // raw words on both sides
        for (int k = 0; k < 20; k++) issue(1'b1, wa[k], 1'b1, wa[k]);
        drain();
        report("write then read", start);

        errors += uut.u_chain_a.u_chk.fails + uut.u_chain_b.u_chk.fails;
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/operand_stage_assertions.sv
//////////////////////////////////////////////////////////////
// chain checks: lane skew, cmen delay, legal shape
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operand_stage_assertions (
    input logic                        clk,
    input logic                        rst,
    input logic                        en,
    input logic                        cmen,
    input logic [1:0]                  shape,
    input logic [stage_pkg::LANES-1:0] en_out,
    input logic [stage_pkg::LANES-1:0] cmen_out
);
    import stage_pkg::*;

    int fails = 0;

    skew_en: assert property (@(posedge clk) disable iff (rst)
        en_out == {$past(en_out[LANES-2:0]), $past(en)})
        else begin
            $error("en_out skew broken");
            fails++;
        end

    skew_cmen: assert property (@(posedge clk) disable iff (rst)
        cmen_out == {$past(cmen_out[LANES-2:0]), $past(cmen)})
        else begin
            $error("cmen_out does not follow the en_out delay");
            fails++;
        end

    legal_shape: assert property (@(posedge clk) disable iff (rst)
        (|en_out) |-> (shape != 2'd3))
        else begin
            $error("illegal shape code with requests in flight");
            fails++;
        end

endmodule

bind operand_chain operand_stage_assertions u_chk (
    .clk(clk), .rst(rst), .en(en), .cmen(cmen), .shape(shape),
    .en_out(en_out), .cmen_out(cmen_out)
);

// File: src/operand_stage_top.sv
//////////////////////////////////////////////////////////////
// operand staging top: A and B chains, shared bank write port
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operand_stage_top (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               en_a,
    input  logic                                               cmen_a,
    input  logic [stage_pkg::ADDR_W-1:0]                       rdaddr_a,
    input  logic                                               en_b,
    input  logic                                               cmen_b,
    input  logic [stage_pkg::ADDR_W-1:0]                       rdaddr_b,
    input  logic [1:0]                                         dtype,
    input  logic [1:0]                                         shape,
    input  logic                                               wr_en,
    input  logic                                               wr_side,  // 0 = A, 1 = B
    input  logic [$clog2(stage_pkg::LANES)-1:0]                wr_lane,
    input  logic [stage_pkg::ADDR_W-1:0]                       wr_addr,
    input  stage_pkg::sram_word_t                              wr_data,
    output logic [stage_pkg::LANES-1:0][stage_pkg::DATA_W-1:0] a_data,
    output logic [stage_pkg::LANES-1:0]                        a_en,
    output logic [stage_pkg::LANES-1:0]                        a_cmen,
    output logic [stage_pkg::LANES-1:0][stage_pkg::DATA_W-1:0] b_data,
    output logic [stage_pkg::LANES-1:0]                        b_en,
    output logic [stage_pkg::LANES-1:0]                        b_cmen
);
    import stage_pkg::*;

    logic [LANES-1:0] lane_sel;
    logic [LANES-1:0] wr_en_a;
    logic [LANES-1:0] wr_en_b;

    // one-hot bank select
    assign lane_sel = wr_en ? (LANES'(1) << wr_lane) : '0;
    assign wr_en_a  = wr_side ? '0 : lane_sel;
    assign wr_en_b  = wr_side ? lane_sel : '0;

    operand_chain #(.SIDE_B(1'b0)) u_chain_a (
        .clk(clk), .rst(rst), .en(en_a), .cmen(cmen_a), .rdaddr(rdaddr_a),
        .dtype(dtype), .shape(shape),
        .wr_en(wr_en_a), .wr_addr(wr_addr), .wr_data(wr_data),
        .data_out(a_data), .en_out(a_en), .cmen_out(a_cmen)
    );

    operand_chain #(.SIDE_B(1'b1)) u_chain_b (
        .clk(clk), .rst(rst), .en(en_b), .cmen(cmen_b), .rdaddr(rdaddr_b),
        .dtype(dtype), .shape(shape),
        .wr_en(wr_en_b), .wr_addr(wr_addr), .wr_data(wr_data),
        .data_out(b_data), .en_out(b_en), .cmen_out(b_cmen)
    );

endmodule

// File: src/operand_chain.sv
//////////////////////////////////////////////////////////////
// one side of the stage: eight banks and eight formatters
// with the request rippling one lane per clock
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operand_chain #(
    parameter bit SIDE_B = 1'b0
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             en,
    input  logic                                             cmen,
    input  logic [stage_pkg::ADDR_W-1:0]                     rdaddr,
    input  logic [1:0]                                       dtype,
    input  logic [1:0]                                       shape,
    input  logic [stage_pkg::LANES-1:0]                      wr_en,
    input  logic [stage_pkg::ADDR_W-1:0]                     wr_addr,
    input  stage_pkg::sram_word_t                            wr_data,
    output logic [stage_pkg::LANES-1:0][stage_pkg::DATA_W-1:0] data_out,
    output logic [stage_pkg::LANES-1:0]                      en_out,
    output logic [stage_pkg::LANES-1:0]                      cmen_out
);
    import stage_pkg::*;

    logic [LANES-1:0]             en_in;
    logic [LANES-1:0]             cmen_in;
    logic [LANES-1:0][ADDR_W-1:0] rdaddr_in;
    logic [LANES-1:0][ADDR_W-1:0] rdaddr_q;
    sram_word_t                   bank_rd [LANES];

    // lane i is fed by lane i-1's registered outputs
    assign en_in     = {en_out[LANES-2:0], en};
    assign cmen_in   = {cmen_out[LANES-2:0], cmen};
    assign rdaddr_in = {rdaddr_q[LANES-2:0], rdaddr};

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        operand_bank u_bank (
            .clk     (clk),
            .wr_en   (wr_en[i]),
            .wr_addr (wr_addr),
            .wr_data (wr_data),
            .rd_addr (rdaddr_in[i]),  // read with the incoming address
            .rd_data (bank_rd[i])
        );

        if (SIDE_B) begin : g_b
            lane_format_b u_fmt (
                .clk(clk), .rst(rst),
                .en_in(en_in[i]), .cmen_in(cmen_in[i]), .rdaddr_in(rdaddr_in[i]),
                .bank_word(bank_rd[i]), .dtype(dtype), .shape(shape),
                .en_out(en_out[i]), .cmen_out(cmen_out[i]),
                .rdaddr_out(rdaddr_q[i]), .data_out(data_out[i])
            );
        end else begin : g_a
            lane_format_a u_fmt (
                .clk(clk), .rst(rst),
                .en_in(en_in[i]), .cmen_in(cmen_in[i]), .rdaddr_in(rdaddr_in[i]),
                .bank_word(bank_rd[i]), .dtype(dtype), .shape(shape),
                .en_out(en_out[i]), .cmen_out(cmen_out[i]),
                .rdaddr_out(rdaddr_q[i]), .data_out(data_out[i])
            );
        end
    end

endmodule

// File: src/lane_format_b.sv
//////////////////////////////////////////////////////////////
// side B lane: skew register stage and operand reformatting
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lane_format_b (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         en_in,
    input  logic                         cmen_in,
    input  logic [stage_pkg::ADDR_W-1:0] rdaddr_in,
    input  stage_pkg::sram_word_t        bank_word,
    input  logic [1:0]                   dtype,
    input  logic [1:0]                   shape,
    output logic                         en_out,
    output logic                         cmen_out,
    output logic [stage_pkg::ADDR_W-1:0] rdaddr_out,
    output logic [stage_pkg::DATA_W-1:0] data_out
);
    import stage_pkg::*;

    logic s;

    assign s = rdaddr_out[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            en_out     <= 1'b0;
            cmen_out   <= 1'b0;
            rdaddr_out <= '0;
        end else begin
            en_out     <= en_in;
            cmen_out   <= cmen_in;
            rdaddr_out <= rdaddr_in;
        end
    end

    always_comb begin
        data_out = bank_word.word;
        case (dtype)
            DT_FP16: begin
                case (shape)
                    SH_SQUARE,
                    SH_NARROW: data_out = {16'h0000, bank_word.half[s]};
                    default:   data_out = bank_word.word;  // 16x8 takes both halves
                endcase
            end
            DT_INT8: begin
                if (shape == SH_WIDE) begin
                    data_out = {4{bank_word.bytes[s]}};  // one byte to all columns
                end
            end
            DT_INT4: begin
                case (shape)
                    SH_WIDE:   data_out = {{4{bank_word.nib[1]}}, {4{bank_word.nib[0]}}};
                    SH_SQUARE: data_out = {2{bank_word.half[0]}};
                    default:   data_out = bank_word.word;
                endcase
            end
            default: data_out = bank_word.word;  // raw
        endcase
    end

endmodule

// File: src/lane_format_a.sv
//////////////////////////////////////////////////////////////
// side A lane: skew register stage and operand reformatting
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lane_format_a (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         en_in,
    input  logic                         cmen_in,
    input  logic [stage_pkg::ADDR_W-1:0] rdaddr_in,
    input  stage_pkg::sram_word_t        bank_word,
    input  logic [1:0]                   dtype,
    input  logic [1:0]                   shape,
    output logic                         en_out,
    output logic                         cmen_out,
    output logic [stage_pkg::ADDR_W-1:0] rdaddr_out,
    output logic [stage_pkg::DATA_W-1:0] data_out
);
    import stage_pkg::*;

    logic       s;
    logic [1:0] b_lo;
    logic [1:0] b_hi;

    assign s    = rdaddr_out[1];  // half select, aligned with bank data
    assign b_lo = {s, 1'b0};
    assign b_hi = {s, 1'b1};

    always_ff @(posedge clk) begin
        if (rst) begin
            en_out     <= 1'b0;
            cmen_out   <= 1'b0;
            rdaddr_out <= '0;
        end else begin
            en_out     <= en_in;
            cmen_out   <= cmen_in;
            rdaddr_out <= rdaddr_in;
        end
    end

    always_comb begin
        data_out = bank_word.word;  // raw code and illegal shape
        case (dtype)
            DT_FP16: data_out = {16'h0000, bank_word.half[s]};
            DT_INT8: begin
                case (shape)
                    SH_SQUARE: data_out = {bank_word.bytes[b_hi], bank_word.bytes[b_hi],
                                           bank_word.bytes[b_lo], bank_word.bytes[b_lo]};
                    SH_NARROW: data_out = {4{bank_word.bytes[s]}};
                    default:   data_out = bank_word.word;  // wide keeps the word
                endcase
            end
            DT_INT4: begin
                case (shape)
                    SH_WIDE: begin
                        // high nibbles over low nibbles
                        data_out = {bank_word.nib[7], bank_word.nib[5],
                                    bank_word.nib[3], bank_word.nib[1],
                                    bank_word.nib[6], bank_word.nib[4],
                                    bank_word.nib[2], bank_word.nib[0]};
                    end
                    SH_SQUARE: data_out = {2{bank_word.nib[3], bank_word.nib[1],
                                             bank_word.nib[2], bank_word.nib[0]}};
                    SH_NARROW: data_out = {{4{bank_word.nib[1]}}, {4{bank_word.nib[0]}}};
                    default:   data_out = bank_word.word;
                endcase
            end
            default: data_out = bank_word.word;
        endcase
    end

endmodule

// File: src/operand_bank.sv
//////////////////////////////////////////////////////////////
// operand bank, 256 x 32 with synchronous write and
// registered read, one per lane
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operand_bank (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic [stage_pkg::ADDR_W-1:0] wr_addr,
    input  stage_pkg::sram_word_t        wr_data,
    input  logic [stage_pkg::ADDR_W-1:0] rd_addr,
    output stage_pkg::sram_word_t        rd_data
);
    import stage_pkg::*;

    sram_word_t mem [BANK_DEPTH];

    // same-word read and write returns the old word
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[ADDR_W-1:2]] <= wr_data;
        end
        rd_data <= mem[rd_addr[ADDR_W-1:2]];  // 1 cycle latency for the skew
    end

endmodule

// File: src/stage_pkg.sv
//////////////////////////////////////////////////////////////
// operand staging package
// lane count, widths, precision and shape codes, bank word view
//////////////////////////////////////////////////////////////
package stage_pkg;

    localparam int LANES      = 8;
    localparam int ADDR_W     = 10;   // byte address
    localparam int BANK_DEPTH = 256;  // word index is addr[9:2]
    localparam int DATA_W     = 32;

    // element precision, code 3 is raw pass-through
    localparam logic [1:0] DT_FP16 = 2'd0;
    localparam logic [1:0] DT_INT8 = 2'd1;
    localparam logic [1:0] DT_INT4 = 2'd2;

    // tile shape, code 3 is illegal
    // side A: wide 32x16, square 16x16, narrow 8x16
    // side B: wide 16x8,  square 16x16, narrow 16x32
    localparam logic [1:0] SH_WIDE   = 2'd0;
    localparam logic [1:0] SH_SQUARE = 2'd1;
    localparam logic [1:0] SH_NARROW = 2'd2;

    // one bank word, decoded per precision
    typedef union packed {
        logic [DATA_W-1:0]  word;
        logic [1:0][15:0]   half;   // fp16 elements
        logic [3:0][7:0]    bytes;  // int8 elements
        logic [7:0][3:0]    nib;    // int4 elements
    } sram_word_t;

endpackage
